//--- logic/pio_pkg.sv
`default_nettype none

package pio_pkg;

    localparam int unsigned data_w       = 32;
    localparam int unsigned be_w         = data_w / 8;
    localparam int unsigned reg_count    = 16;
    localparam int unsigned reg_addr_w   = $clog2(reg_count);  // Request address bits 5:2
    localparam int unsigned len_w        = 10;
    localparam int unsigned lower_addr_w = 7;

    // Format and type, header dword 0 bits 30:24
    localparam logic [6:0] fmt_type_mrd32 = 7'b00_00000;
    localparam logic [6:0] fmt_type_mwr32 = 7'b10_00000;
    localparam logic [6:0] fmt_type_cpld  = 7'b10_01010;

    // "REGT", read back from register 0
    localparam logic [data_w-1:0] id_reg_value = 32'h5245_4754;

    localparam logic [11:0] cpl_byte_count = 12'd4;

    // Header dword 1, request side and completion side
    typedef union packed {
        struct packed {
            logic [15:0] requester_id;
            logic [7:0]  tag;
            logic [3:0]  last_be;
            logic [3:0]  first_be;
        } req;
        struct packed {
            logic [15:0] completer_id;
            logic [2:0]  status;
            logic        bcm;
            logic [11:0] byte_count;
        } cpl;
    } tlp_dw1_u;

endpackage

`default_nettype wire

//--- logic/pio_rx_engine.sv
`default_nettype none

module pio_rx_engine (
    input  logic                              user_clk,
    input  logic                              reset,
    input  logic [pio_pkg::data_w-1:0]        rx_tdata,
    input  logic                              rx_tvalid,
    input  logic                              rx_tlast,
    output logic                              rx_tready,
    input  logic                              cpl_busy,
    output logic                              wr_en,
    output logic [pio_pkg::reg_addr_w-1:0]    wr_addr,
    output logic [pio_pkg::data_w-1:0]        wr_data,
    output logic [pio_pkg::be_w-1:0]          wr_be,
    output logic                              rd_en,
    output logic [pio_pkg::reg_addr_w-1:0]    rd_addr,
    output logic                              cpl_req,
    output pio_pkg::tlp_dw1_u                 cpl_dw1,
    output logic [pio_pkg::lower_addr_w-1:0]  cpl_lower_addr
);

    logic                           rx_beat;
    logic [1:0]                     beat_q;      // Saturates at the data dword
    logic                           keep_q;
    logic                           is_wr_q;
    pio_pkg::tlp_dw1_u              dw1_q;
    logic [pio_pkg::reg_addr_w-1:0] addr_q;
    logic                           last_rd_beat;
    logic                           last_wr_beat;
    logic [6:0]                     fmt_type;
    logic [pio_pkg::len_w-1:0]      length;

    assign fmt_type = rx_tdata[30:24];
    assign length   = rx_tdata[pio_pkg::len_w-1:0];

    // Only stall between TLPs, one read in flight
    assign rx_tready = !(beat_q == 2'd0 && cpl_busy);
    assign rx_beat   = rx_tvalid && rx_tready;

    assign last_rd_beat = rx_beat && beat_q == 2'd2 && !is_wr_q;
    assign last_wr_beat = rx_beat && beat_q == 2'd3 && is_wr_q;

    always_ff @(posedge user_clk) begin
        if (reset) begin
            beat_q  <= 2'd0;
            keep_q  <= 1'b0;
            is_wr_q <= 1'b0;
        end else if (rx_beat) begin
            if (rx_tlast)
                beat_q <= 2'd0;
            else if (beat_q != 2'd3)
                beat_q <= beat_q + 2'd1;

            if (beat_q == 2'd0) begin
                keep_q  <= (fmt_type == pio_pkg::fmt_type_mrd32 ||
                            fmt_type == pio_pkg::fmt_type_mwr32) && length == 10'd1;
                is_wr_q <= fmt_type == pio_pkg::fmt_type_mwr32;
            end else if (last_rd_beat || last_wr_beat) begin
                keep_q <= 1'b0;  // Trailing beats are dropped
            end
        end
    end

    always_ff @(posedge user_clk) begin
        if (reset) begin
            wr_en <= 1'b0;
            rd_en <= 1'b0;
        end else begin
            wr_en <= last_wr_beat && keep_q && rx_tlast;
            rd_en <= last_rd_beat && keep_q && rx_tlast;
        end
    end

    assign cpl_req = rd_en;

    always_ff @(posedge user_clk) begin
        if (rx_beat && beat_q == 2'd1)
            dw1_q <= rx_tdata;
        if (rx_beat && beat_q == 2'd2)
            addr_q <= rx_tdata[pio_pkg::reg_addr_w+1:2];
        if (last_wr_beat) begin
            wr_data <= rx_tdata;
            wr_addr <= addr_q;
            wr_be   <= dw1_q.req.first_be;
        end
        if (last_rd_beat) begin
            rd_addr        <= rx_tdata[pio_pkg::reg_addr_w+1:2];
            cpl_dw1        <= dw1_q;
            cpl_lower_addr <= {rx_tdata[pio_pkg::lower_addr_w-1:2], 2'b00};
        end
    end

    // A read retires alone and never while a completion is pending
    assert property (@(posedge user_clk) disable iff (reset)
        rd_en |-> !wr_en && !$past(cpl_busy));

endmodule

`default_nettype wire

//--- logic/pio_reg_file.sv
`default_nettype none

module pio_reg_file (
    input  logic                           user_clk,
    input  logic                           reset,
    input  logic                           wr_en,
    input  logic [pio_pkg::reg_addr_w-1:0] wr_addr,
    input  logic [pio_pkg::data_w-1:0]     wr_data,
    input  logic [pio_pkg::be_w-1:0]       wr_be,
    input  logic                           rd_en,
    input  logic [pio_pkg::reg_addr_w-1:0] rd_addr,
    output logic [pio_pkg::data_w-1:0]     rd_data
);

    // Address 0 is the ID word
    logic [pio_pkg::data_w-1:0] regs [1:pio_pkg::reg_count-1];

    always_ff @(posedge user_clk) begin
        if (reset) begin
            for (int i = 1; i < pio_pkg::reg_count; i++)
                regs[i] <= '0;
        end else if (wr_en && wr_addr != '0) begin
            for (int b = 0; b < pio_pkg::be_w; b++) begin
                if (wr_be[b])
                    regs[wr_addr][8*b +: 8] <= wr_data[8*b +: 8];
            end
        end
    end

    // Held until the next read
    always_ff @(posedge user_clk) begin
        if (rd_en) begin
            if (rd_addr == '0)
                rd_data <= pio_pkg::id_reg_value;
            else
                rd_data <= regs[rd_addr];
        end
    end

endmodule

`default_nettype wire

//--- logic/pio_tx_engine.sv
`default_nettype none

module pio_tx_engine (
    input  logic                              user_clk,
    input  logic                              reset,
    input  logic                              cpl_req,
    input  pio_pkg::tlp_dw1_u                 cpl_dw1,
    input  logic [pio_pkg::lower_addr_w-1:0]  cpl_lower_addr,
    input  logic [pio_pkg::data_w-1:0]        rd_data,
    input  logic [15:0]                       completer_id,
    output logic [pio_pkg::data_w-1:0]        tx_tdata,
    output logic                              tx_tvalid,
    output logic                              tx_tlast,
    input  logic                              tx_tready,
    output logic                              cpl_busy
);

    logic                             active_q;
    logic [1:0]                       beat_q;
    pio_pkg::tlp_dw1_u                cpl_view;
    pio_pkg::tlp_dw1_u                hdr1_q;     // Completion view
    pio_pkg::tlp_dw1_u                req_q;      // Request view
    logic [pio_pkg::lower_addr_w-1:0] lower_addr_q;
    logic [pio_pkg::data_w-1:0]       data_q;

    always_comb begin
        cpl_view                 = '0;
        cpl_view.cpl.completer_id = completer_id;
        cpl_view.cpl.status      = 3'b000;  // Successful completion
        cpl_view.cpl.bcm         = 1'b0;
        cpl_view.cpl.byte_count  = pio_pkg::cpl_byte_count;
    end

    always_ff @(posedge user_clk) begin
        if (reset) begin
            active_q <= 1'b0;
            beat_q   <= 2'd0;
        end else if (cpl_req) begin
            active_q <= 1'b1;
            beat_q   <= 2'd0;
        end else if (active_q && tx_tready) begin
            if (beat_q == 2'd3)
                active_q <= 1'b0;
            beat_q <= beat_q + 2'd1;  // Wraps back to dword 0
        end
    end

    always_ff @(posedge user_clk) begin
        if (cpl_req) begin
            hdr1_q       <= cpl_view;
            req_q        <= cpl_dw1;
            lower_addr_q <= cpl_lower_addr;
        end
        // Read data lands during the first beat
        if (active_q && beat_q == 2'd0)
            data_q <= rd_data;
    end

    always_comb begin
        case (beat_q)
            2'd0:    tx_tdata = {1'b0, pio_pkg::fmt_type_cpld, 14'd0, 10'd1};
            2'd1:    tx_tdata = hdr1_q;
            2'd2:    tx_tdata = {req_q.req.requester_id, req_q.req.tag, 1'b0, lower_addr_q};
            default: tx_tdata = data_q;
        endcase
    end

    assign tx_tvalid = active_q;
    assign tx_tlast  = beat_q == 2'd3;
    assign cpl_busy  = cpl_req || active_q;

    // Beat holds while the core stalls
    assert property (@(posedge user_clk) disable iff (reset)
        tx_tvalid && !tx_tready |=> tx_tvalid && $stable(tx_tdata));

endmodule

`default_nettype wire

//--- logic/pio_endpoint.sv
`default_nettype none

module pio_endpoint (
    input  logic                       user_clk,
    input  logic                       reset,
    input  logic [pio_pkg::data_w-1:0] m_axis_rx_tdata,
    input  logic                       m_axis_rx_tvalid,
    input  logic                       m_axis_rx_tlast,
    output logic                       m_axis_rx_tready,
    output logic [pio_pkg::data_w-1:0] s_axis_tx_tdata,
    output logic                       s_axis_tx_tvalid,
    output logic                       s_axis_tx_tlast,
    input  logic                       s_axis_tx_tready,
    input  logic [7:0]                 cfg_bus_number,
    input  logic [4:0]                 cfg_device_number,
    input  logic [2:0]                 cfg_function_number
);

    logic                             wr_en;
    logic [pio_pkg::reg_addr_w-1:0]   wr_addr;
    logic [pio_pkg::data_w-1:0]       wr_data;
    logic [pio_pkg::be_w-1:0]         wr_be;
    logic                             rd_en;
    logic [pio_pkg::reg_addr_w-1:0]   rd_addr;
    logic [pio_pkg::data_w-1:0]       rd_data;
    logic                             cpl_req;
    logic                             cpl_busy;
    pio_pkg::tlp_dw1_u                cpl_dw1;
    logic [pio_pkg::lower_addr_w-1:0] cpl_lower_addr;
    logic [15:0]                      completer_id;

    assign completer_id = {cfg_bus_number, cfg_device_number, cfg_function_number};

    pio_rx_engine rx_engine_inst (
        .user_clk       (user_clk),
        .reset          (reset),
        .rx_tdata       (m_axis_rx_tdata),
        .rx_tvalid      (m_axis_rx_tvalid),
        .rx_tlast       (m_axis_rx_tlast),
        .rx_tready      (m_axis_rx_tready),
        .cpl_busy       (cpl_busy),
        .wr_en          (wr_en),
        .wr_addr        (wr_addr),
        .wr_data        (wr_data),
        .wr_be          (wr_be),
        .rd_en          (rd_en),
        .rd_addr        (rd_addr),
        .cpl_req        (cpl_req),
        .cpl_dw1        (cpl_dw1),
        .cpl_lower_addr (cpl_lower_addr)
    );

    pio_reg_file reg_file_inst (
        .user_clk (user_clk),
        .reset    (reset),
        .wr_en    (wr_en),
        .wr_addr  (wr_addr),
        .wr_data  (wr_data),
        .wr_be    (wr_be),
        .rd_en    (rd_en),
        .rd_addr  (rd_addr),
        .rd_data  (rd_data)
    );

    pio_tx_engine tx_engine_inst (
        .user_clk       (user_clk),
        .reset          (reset),
        .cpl_req        (cpl_req),
        .cpl_dw1        (cpl_dw1),
        .cpl_lower_addr (cpl_lower_addr),
        .rd_data        (rd_data),
        .completer_id   (completer_id),
        .tx_tdata       (s_axis_tx_tdata),
        .tx_tvalid      (s_axis_tx_tvalid),
        .tx_tlast       (s_axis_tx_tlast),
        .tx_tready      (s_axis_tx_tready),
        .cpl_busy       (cpl_busy)
    );

endmodule

`default_nettype wire

//--- dv/pio_endpoint_tb.sv
`default_nettype none

module pio_endpoint_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam logic [7:0]  bus_number         = 8'h3a;
    localparam logic [4:0]  device_number      = 5'h05;
    localparam logic [2:0]  function_number    = 3'h2;
    localparam logic [15:0] requester_id       = 16'hab01;
    localparam int          max_patterns       = 64;
    localparam int          cycles_per_pattern = 40;

    logic        user_clk = 1'b0;
    logic        reset;
    logic [31:0] m_axis_rx_tdata;
    logic        m_axis_rx_tvalid;
    logic        m_axis_rx_tlast;
    logic        m_axis_rx_tready;
    logic [31:0] s_axis_tx_tdata;
    logic        s_axis_tx_tvalid;
    logic        s_axis_tx_tlast;
    logic        s_axis_tx_tready;
    logic [7:0]  cfg_bus_number;
    logic [4:0]  cfg_device_number;
    logic [2:0]  cfg_function_number;

    logic [63:0] pat_op   [max_patterns];
    logic [31:0] pat_addr [max_patterns];
    logic [31:0] pat_data [max_patterns];
    logic [31:0] pat_be   [max_patterns];
    logic [31:0] pat_exp  [max_patterns];
    int          pattern_count = 0;
    logic        patterns_loaded = 1'b0;

    // One entry per read still waiting for its completion
    int          exp_test [$];
    logic [31:0] exp_dw2  [$];
    logic [31:0] exp_data [$];

    logic [7:0]  next_tag = 8'h10;
    logic [1:0]  tx_beat = 2'd0;
    int          errors = 0;
    int          errors_at_cpl = 0;
    int          reads_checked = 0;
    int          tests_failed = 0;
    int          i;

    pio_endpoint pio_endpoint_inst (
        .user_clk            (user_clk),
        .reset               (reset),
        .m_axis_rx_tdata     (m_axis_rx_tdata),
        .m_axis_rx_tvalid    (m_axis_rx_tvalid),
        .m_axis_rx_tlast     (m_axis_rx_tlast),
        .m_axis_rx_tready    (m_axis_rx_tready),
        .s_axis_tx_tdata     (s_axis_tx_tdata),
        .s_axis_tx_tvalid    (s_axis_tx_tvalid),
        .s_axis_tx_tlast     (s_axis_tx_tlast),
        .s_axis_tx_tready    (s_axis_tx_tready),
        .cfg_bus_number      (cfg_bus_number),
        .cfg_device_number   (cfg_device_number),
        .cfg_function_number (cfg_function_number)
    );

    always #50 user_clk = ~user_clk;

    task automatic compare_word(input string name, input logic [31:0] expected,
                                input logic [31:0] actual);
        if (actual !== expected) begin
            $display("MISMATCH at %0d ns: %s expected %h actual %h",
                     $time, name, expected, actual);
            errors++;
        end
    endtask

    task automatic load_patterns();
        int          fd;
        int          code;
        int          fields;
        string       line;
        logic [63:0] op;
        logic [31:0] addr;
        logic [31:0] data;
        logic [31:0] be;
        logic [31:0] expected;
        fd = $fopen("dv/tlp_patterns.txt", "r");
        if (fd == 0) begin
            $display("error: cannot open dv/tlp_patterns.txt");
            errors++;
        end else begin
            while (!$feof(fd) && pattern_count < max_patterns) begin
                code = $fgets(line, fd);
                if (code != 0) begin
                    fields = $sscanf(line, "%s %h %h %h %h", op, addr, data, be, expected);
                    if (fields == 5) begin  // Comment and blank lines fall out here
                        pat_op[pattern_count]   = op;
                        pat_addr[pattern_count] = addr;
                        pat_data[pattern_count] = data;
                        pat_be[pattern_count]   = be;
                        pat_exp[pattern_count]  = expected;
                        pattern_count++;
                    end
                end
            end
            $fclose(fd);
        end
        patterns_loaded = 1'b1;
    endtask

    // Called on a falling edge, returns on the falling edge after the beat is taken
    task automatic send_beat(input logic [31:0] data, input logic last);
        m_axis_rx_tdata  = data;
        m_axis_rx_tvalid = 1'b1;
        m_axis_rx_tlast  = last;
        while (!m_axis_rx_tready)
            @(negedge user_clk);
        @(negedge user_clk);
    endtask

    task automatic run_pattern(input int idx);
        logic [31:0] dw1;
        logic [31:0] dw2;
        logic [31:0] hdr;
        int          beats;
        int          b;
        dw1 = {requester_id, next_tag, 4'h0, pat_be[idx][3:0]};
        dw2 = {pat_addr[idx][31:2], 2'b00};
        if (pat_op[idx] == {24'd0, "write"}) begin
            send_beat(32'h4000_0001, 1'b0);  // MWr32, one dword
            send_beat(dw1, 1'b0);
            send_beat(dw2, 1'b0);
            send_beat(pat_data[idx], 1'b1);
            $display("test %0d write addr %h be %h data %h: sent",
                     idx + 1, pat_addr[idx][7:0], pat_be[idx][3:0], pat_data[idx]);
        end else if (pat_op[idx] == {32'd0, "read"}) begin
            exp_test.push_back(idx + 1);
            exp_dw2.push_back({requester_id, next_tag, 1'b0, pat_addr[idx][6:2], 2'b00});
            exp_data.push_back(pat_exp[idx]);
            send_beat(32'h0000_0001, 1'b0);  // MRd32, one dword
            send_beat(dw1, 1'b0);
            send_beat(dw2, 1'b1);
            next_tag++;
        end else if (pat_op[idx] == {40'd0, "bad"}) begin
            hdr   = pat_data[idx];
            // 4DW header when fmt bit 0 is set, payload only when fmt bit 1 is set
            beats = (hdr[29] ? 4 : 3) + (hdr[30] ? int'(hdr[9:0]) : 0);
            send_beat(hdr, 1'b0);
            send_beat(dw1, 1'b0);
            for (b = 2; b < beats; b++)
                send_beat((b == 2) ? dw2 : 32'hbad0_0000 + b, b == beats - 1);
            $display("test %0d bad header %h, %0d beats: sent", idx + 1, hdr, beats);
        end else begin
            $display("error: test %0d has an unknown operation in the pattern file", idx + 1);
            errors++;
        end
        m_axis_rx_tvalid = 1'b0;
        m_axis_rx_tlast  = 1'b0;
    endtask

    // Completion monitor, a beat counts when tvalid meets the tready just driven
    always @(negedge user_clk) begin
        s_axis_tx_tready = (($urandom % 4) != 0);
        // RX side stays stalled while a completion is on the wire
        if (!reset && s_axis_tx_tvalid)
            compare_word("m_axis_rx_tready", 32'd0, {31'd0, m_axis_rx_tready});
        if (!reset && s_axis_tx_tvalid && s_axis_tx_tready) begin
            if (exp_test.size() == 0) begin
                $display("error at %0d ns: completion beat with no read outstanding", $time);
                errors++;
            end else begin
                if (tx_beat == 2'd0)
                    errors_at_cpl = errors;
                case (tx_beat)
                    2'd0:    compare_word("s_axis_tx_tdata dw0", 32'h4a00_0001, s_axis_tx_tdata);
                    2'd1:    compare_word("s_axis_tx_tdata dw1",
                                          {bus_number, device_number, function_number,
                                           3'b000, 1'b0, 12'd4}, s_axis_tx_tdata);
                    2'd2:    compare_word("s_axis_tx_tdata dw2", exp_dw2[0], s_axis_tx_tdata);
                    default: compare_word("s_axis_tx_tdata dw3", exp_data[0], s_axis_tx_tdata);
                endcase
                compare_word("s_axis_tx_tlast", {31'd0, tx_beat == 2'd3},
                             {31'd0, s_axis_tx_tlast});
                if (tx_beat == 2'd3) begin
                    if (errors == errors_at_cpl) begin
                        $display("test %0d read: pass, data %h", exp_test[0], exp_data[0]);
                    end else begin
                        $display("test %0d read: FAIL", exp_test[0]);
                        tests_failed++;
                    end
                    reads_checked++;
                    exp_test.delete(0);
                    exp_dw2.delete(0);
                    exp_data.delete(0);
                end
                tx_beat = tx_beat + 2'd1;
            end
        end
    end

    initial begin
        void'($urandom(32'hee51));
        reset               = 1'b1;
        m_axis_rx_tdata     = 32'd0;
        m_axis_rx_tvalid    = 1'b0;
        m_axis_rx_tlast     = 1'b0;
        s_axis_tx_tready    = 1'b0;
        cfg_bus_number      = bus_number;
        cfg_device_number   = device_number;
        cfg_function_number = function_number;
        load_patterns();
        repeat (16) @(negedge user_clk);
        reset = 1'b0;
        compare_word("m_axis_rx_tready", 32'd1, {31'd0, m_axis_rx_tready});
        compare_word("s_axis_tx_tvalid", 32'd0, {31'd0, s_axis_tx_tvalid});
        if (errors == 0)
            $display("reset state: pass");
        else
            $display("reset state: FAIL");
        repeat (2) @(negedge user_clk);
        for (i = 0; i < pattern_count; i++)
            run_pattern(i);
        while (exp_test.size() != 0)
            @(negedge user_clk);
        repeat (20) @(negedge user_clk);  // Window for stray completions
        $display("%0d tests, %0d reads checked, %0d reads failed, %0d errors",
                 pattern_count, reads_checked, tests_failed, errors);
        if (errors == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

    initial begin
        wait (patterns_loaded);
        repeat (16 + cycles_per_pattern * (pattern_count + 1)) @(posedge user_clk);
        $display("timeout: the run did not finish within %0d cycles",
                 16 + cycles_per_pattern * (pattern_count + 1));
        $display("Done: errors found");
        $finish;
    end

endmodule

`default_nettype wire

//--- dv/tlp_patterns.txt
# op     address  data      be  expected read value (hex)
# rows marked bad carry header dword 0 in the data column
read     00       00000000  f   52454754
write    00       12345678  f   00000000
read     00       00000000  f   52454754
write    04       a5a5a5a5  f   00000000
read     04       00000000  f   a5a5a5a5
write    08       11223344  f   00000000
write    0c       cafef00d  f   00000000
read     08       00000000  f   11223344
read     0c       00000000  f   cafef00d
write    08       ffffffff  5   00000000
read     08       00000000  f   11ff33ff
write    0c       00000000  8   00000000
read     0c       00000000  f   00fef00d
write    10       deadbeef  0   00000000
read     10       00000000  f   00000000
write    54       87654321  f   00000000
read     14       00000000  f   87654321
read     54       00000000  f   87654321
bad      04       40000002  f   00000000
read     04       00000000  f   a5a5a5a5
bad      08       00000002  f   00000000
bad      0c       04000001  f   00000000
bad      0c       60000001  f   00000000
read     0c       00000000  f   00fef00d
read     08       00000000  f   11ff33ff
write    3c       0f0f0f0f  3   00000000
read     3c       00000000  f   00000f0f
read     00       00000000  f   52454754

//--- project.f
logic/pio_pkg.sv
logic/pio_rx_engine.sv
logic/pio_reg_file.sv
logic/pio_tx_engine.sv
logic/pio_endpoint.sv
dv/pio_endpoint_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build with Verilator, run, and judge the run from its log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f project.f --top-module pio_endpoint_tb \
    && ./obj_dir/Vpio_endpoint_tb > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qx "Done: no errors" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
